//--- Bender.yml
package:
  name: mem_subsystem

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/mem_bus_pkg.sv
      - src/cache_pkg.sv
      - src/mem_arbiter.sv
      - src/inst_cache.sv
      - src/tagged_memory.sv
      - src/mem_subsystem.sv
      - target: test
        files:
          - test/mem_subsystem_tb.sv

//--- sources.f
+incdir+src
src/mem_bus_pkg.sv
src/cache_pkg.sv
src/mem_arbiter.sv
src/inst_cache.sv
src/tagged_memory.sv
src/mem_subsystem.sv
test/mem_subsystem_tb.sv

//--- src/cache_pkg.sv
`include "mem_config.svh"

package cache_pkg;

    // One instruction cache line holds a single 64-bit word
    typedef struct packed {
        logic [63:0]                 data;
        logic [`ICACHE_TAG_BITS-1:0] tag;
        logic                        valid;
    } cache_line_t;

    // Address as seen by the cache
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0] tag;
        logic [`ICACHE_SET_BITS-1:0] set;
        logic [`MEM_OFFSET_BITS-1:0] offset;
    } cache_fields_t;

    // Address as seen by the main memory
    typedef struct packed {
        logic [`MEM_INDEX_BITS-1:0]  index;
        logic [`MEM_OFFSET_BITS-1:0] offset;
    } word_fields_t;

    // Same 13-bit address, decoded by cache or by memory
    typedef union packed {
        cache_fields_t cache;
        word_fields_t  word;
    } mem_addr_t;

endpackage

//--- src/inst_cache.sv
`include "mem_config.svh"

module inst_cache (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      fetch_valid,
    input  cache_pkg::mem_addr_t      fetch_addr,
    output logic [63:0]               fetch_data,
    output logic                      fetch_hit,
    output mem_bus_pkg::mem_request_t imem_request,
    input  mem_bus_pkg::mem_reply_t   imem_reply
);

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQUEST,
        FILL_WAIT
    } fill_state_t;

    cache_pkg::cache_line_t lines [`ICACHE_SETS];
    cache_pkg::cache_line_t hit_line;
    fill_state_t            state;
    cache_pkg::mem_addr_t   miss_addr;
    cache_pkg::mem_addr_t   request_addr;
    mem_bus_pkg::mem_tag_t  miss_tag;
    logic                   lookup_hit;
    logic                   fetch_miss;
    logic                   request_accepted;
    logic                   fill_done;

    // Lookup
    assign hit_line   = lines[fetch_addr.cache.set];
    assign lookup_hit = hit_line.valid && (hit_line.tag == fetch_addr.cache.tag);
    assign fetch_hit  = fetch_valid && lookup_hit;
    assign fetch_data = hit_line.data;
    assign fetch_miss = fetch_valid && !lookup_hit;

    // A fresh miss goes out in the same cycle; a refused one is replayed
    // from the latched address
    always_comb begin
        imem_request = '0;
        request_addr = (state == FILL_IDLE) ? fetch_addr : miss_addr;
        if ((state == FILL_IDLE && fetch_miss) || state == FILL_REQUEST) begin
            imem_request.command = mem_bus_pkg::BUS_LOAD;
            imem_request.address = request_addr;
        end
    end

    assign request_accepted = (imem_request.command != mem_bus_pkg::BUS_NONE)
                              && (imem_reply.response != '0);
    assign fill_done        = (state == FILL_WAIT) && (imem_reply.tag == miss_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= FILL_IDLE;
        end else begin
            case (state)
                FILL_IDLE: begin
                    if (fetch_miss) begin
                        state <= request_accepted ? FILL_WAIT : FILL_REQUEST;
                    end
                end
                FILL_REQUEST: begin
                    if (request_accepted) begin
                        state <= FILL_WAIT;
                    end
                end
                FILL_WAIT: begin
                    if (fill_done) begin
                        state <= FILL_IDLE;
                    end
                end
                default: state <= FILL_IDLE;
            endcase
        end
    end

    // Miss address and the tag the memory handed out
    always_ff @(posedge clock) begin
        if (state == FILL_IDLE) begin
            miss_addr <= fetch_addr;
        end
        if (request_accepted) begin
            miss_tag <= imem_reply.response;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                lines[s].valid <= 1'b0;
            end
        end else if (fill_done) begin
            lines[miss_addr.cache.set] <= '{
                data:  imem_reply.data,
                tag:   miss_addr.cache.tag,
                valid: 1'b1
            };
        end
    end

    // Once a load is accepted the bus stays quiet until its data returns
    assert property (@(posedge clock) disable iff (reset)
        request_accepted |=> (imem_request.command == mem_bus_pkg::BUS_NONE)
            until_with (imem_reply.tag == miss_tag));

endmodule

//--- src/mem_arbiter.sv
module mem_arbiter (
    input  logic                     clock,
    input  logic                     reset,
    input  mem_bus_pkg::mem_request_t dmem_request,
    output mem_bus_pkg::mem_reply_t   dmem_reply,
    input  mem_bus_pkg::mem_request_t imem_request,
    output mem_bus_pkg::mem_reply_t   imem_reply,
    output mem_bus_pkg::mem_request_t mem_request,
    input  mem_bus_pkg::mem_reply_t   mem_reply
);

    typedef enum logic [1:0] {
        IDLE,
        IMEM,
        DMEM
    } arb_state_t;

    arb_state_t state;
    arb_state_t owner;
    logic       dmem_active;
    logic       imem_active;

    assign dmem_active = (dmem_request.command != mem_bus_pkg::BUS_NONE);
    assign imem_active = (imem_request.command != mem_bus_pkg::BUS_NONE);

    // Owner for this cycle
    // The current owner keeps the bus while it presents, a quiet owner hands over
    always_comb begin
        owner = IDLE;
        case (state)
            IMEM: begin
                if (imem_active) begin
                    owner = IMEM;
                end else if (dmem_active) begin
                    owner = DMEM;
                end
            end
            default: begin
                // Data port has priority from IDLE
                if (dmem_active) begin
                    owner = DMEM;
                end else if (imem_active) begin
                    owner = IMEM;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= owner;
        end
    end

    always_comb begin
        mem_request = '0;
        case (owner)
            DMEM:    mem_request = dmem_request;
            IMEM:    mem_request = imem_request;
            default: mem_request = '0;
        endcase
    end

    // Data and data tag go to both ports, each client matches its own tag
    always_comb begin
        dmem_reply = mem_reply;
        imem_reply = mem_reply;
        if (owner != DMEM) begin
            dmem_reply.response = '0;
        end
        if (owner != IMEM) begin
            imem_reply.response = '0;
        end
    end

    // Never accept for both clients at once
    assert property (@(posedge clock) disable iff (reset)
        !((dmem_reply.response != '0) && (imem_reply.response != '0)));

endmodule

//--- src/mem_bus_pkg.sv
`include "mem_config.svh"

package mem_bus_pkg;

    // Command encoding on the shared memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_command_t;

    // Transaction tag, zero means no tag
    typedef logic [3:0] mem_tag_t;

    typedef logic [63:0] mem_word_t;

    // Driven by a client and held until a non-zero response comes back
    typedef struct packed {
        bus_command_t                command;
        logic [`MEM_ADDR_BITS-1:0]   address;
        mem_word_t                   data;
    } mem_request_t;

    // Response tag is same-cycle acceptance
    // Data tag marks the one cycle in which load data is valid
    typedef struct packed {
        mem_tag_t  response;
        mem_word_t data;
        mem_tag_t  tag;
    } mem_reply_t;

endpackage

//--- src/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Byte address width, an 8 KB space
`define MEM_ADDR_BITS 13

// Byte offset inside one 64-bit word
`define MEM_OFFSET_BITS 3

// Main memory depth in 64-bit words
`define MEM_WORDS 1024

`define MEM_INDEX_BITS $clog2(`MEM_WORDS)

// Cycles from load acceptance to data
// Must stay below 15 so that no two loads in flight share a tag
`define MEM_LATENCY 6

// Instruction cache geometry, one word per line
`define ICACHE_SETS 16

`define ICACHE_SET_BITS $clog2(`ICACHE_SETS)

`define ICACHE_TAG_BITS (`MEM_ADDR_BITS - `ICACHE_SET_BITS - `MEM_OFFSET_BITS)

`endif

//--- src/mem_subsystem.sv
module mem_subsystem (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_bus_pkg::mem_request_t dmem_request,
    output mem_bus_pkg::mem_reply_t   dmem_reply,
    input  logic                      fetch_valid,
    input  cache_pkg::mem_addr_t      fetch_addr,
    output logic [63:0]               fetch_data,
    output logic                      fetch_hit
);

    // Cache to arbiter
    mem_bus_pkg::mem_request_t imem_request;
    mem_bus_pkg::mem_reply_t   imem_reply;

    // Arbiter to memory
    mem_bus_pkg::mem_request_t mem_request;
    mem_bus_pkg::mem_reply_t   mem_reply;

    inst_cache u_inst_cache (
        .clock        (clock),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_hit    (fetch_hit),
        .imem_request (imem_request),
        .imem_reply   (imem_reply)
    );

    mem_arbiter u_mem_arbiter (
        .clock        (clock),
        .reset        (reset),
        .dmem_request (dmem_request),
        .dmem_reply   (dmem_reply),
        .imem_request (imem_request),
        .imem_reply   (imem_reply),
        .mem_request  (mem_request),
        .mem_reply    (mem_reply)
    );

    tagged_memory u_tagged_memory (
        .clock       (clock),
        .reset       (reset),
        .mem_request (mem_request),
        .mem_reply   (mem_reply)
    );

endmodule

//--- src/tagged_memory.sv
`include "mem_config.svh"

module tagged_memory (
    input  logic                      clock,
    input  logic                      reset,
    input  mem_bus_pkg::mem_request_t mem_request,
    output mem_bus_pkg::mem_reply_t   mem_reply
);

    // Control part of one load pipeline slot
    typedef struct packed {
        logic                  valid;
        mem_bus_pkg::mem_tag_t tag;
    } slot_ctrl_t;

    logic [63:0]                        words [`MEM_WORDS];
    cache_pkg::mem_addr_t               addr;
    mem_bus_pkg::mem_tag_t              next_tag;
    slot_ctrl_t                         new_slot;
    slot_ctrl_t [`MEM_LATENCY-1:0]      slot_ctrl;
    logic [`MEM_LATENCY-1:0][63:0]      slot_data;
    logic                               is_load;
    logic                               is_command;

    // Word i holds c0de_0000 over i
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            words[i] = {32'hc0de_0000, 32'(i)};
        end
    end

    assign addr       = mem_request.address;
    assign is_command = (mem_request.command != mem_bus_pkg::BUS_NONE);
    assign is_load    = (mem_request.command == mem_bus_pkg::BUS_LOAD);

    // Every command is accepted
    assign mem_reply.response = is_command ? next_tag : '0;

    // Invalid slots carry tag zero
    assign new_slot = '{valid: is_load, tag: (is_load ? next_tag : '0)};

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag  <= 4'd1;
            slot_ctrl <= '0;
        end else begin
            if (is_command) begin
                next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            slot_ctrl <= {slot_ctrl[`MEM_LATENCY-2:0], new_slot};
        end
    end

    always @(posedge clock) begin
        if (mem_request.command == mem_bus_pkg::BUS_STORE) begin
            words[addr.word.index] <= mem_request.data;
        end
    end

    // Read at acceptance, then delay
    always_ff @(posedge clock) begin
        slot_data <= {slot_data[`MEM_LATENCY-2:0], words[addr.word.index]};
    end

    assign mem_reply.data = slot_data[`MEM_LATENCY-1];
    assign mem_reply.tag  = slot_ctrl[`MEM_LATENCY-1].tag;

    // A data tag shows exactly when the last slot holds a load
    assert property (@(posedge clock) disable iff (reset)
        (mem_reply.tag != '0) == slot_ctrl[`MEM_LATENCY-1].valid);

    // Load data comes back with its own tag after the fixed latency
    assert property (@(posedge clock) disable iff (reset)
        is_load |-> ##`MEM_LATENCY
            (mem_reply.tag == $past(mem_reply.response, `MEM_LATENCY)));

endmodule

//--- test/mem_subsystem_tb.sv
`include "mem_config.svh"

module mem_subsystem_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum {
        OP_STORE,
        OP_LOAD,
        OP_FETCH
    } op_t;

    typedef struct {
        op_t         kind;
        logic [12:0] addr;
        logic [63:0] data;
        logic [63:0] expected;
        bit          hit;    // fetch should hit in the cycle it is presented
        bit          drain;  // data port goes idle and waits for its loads
        int          burst;  // data loads presented together with a fetch
        logic [12:0] side;   // address of the first of those loads
    } row_t;

    typedef struct {
        mem_bus_pkg::mem_tag_t tag;
        logic [63:0]           expected;
        time                   accepted;
    } load_entry_t;

    logic                      clock;
    logic                      reset;
    mem_bus_pkg::mem_request_t dmem_request;
    mem_bus_pkg::mem_reply_t   dmem_reply;
    logic                      fetch_valid;
    cache_pkg::mem_addr_t      fetch_addr;
    logic [63:0]               fetch_data;
    logic                      fetch_hit;

    // Reference copy of main memory
    logic [63:0]           shadow [`MEM_WORDS];
    row_t                  rows [$];
    load_entry_t           pending [$];
    load_entry_t           returned;
    mem_bus_pkg::mem_tag_t last_tag;
    int                    cycles = 0;
    int                    cycle_limit = 0;
    int                    error_count = 0;

    mem_subsystem uut (
        .clock        (clock),
        .reset        (reset),
        .dmem_request (dmem_request),
        .dmem_reply   (dmem_reply),
        .fetch_valid  (fetch_valid),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_hit    (fetch_hit)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the test did not finish", cycles);
            $display("Finished with errors");
            $fatal(1, "Timeout");
        end
    end

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic void add_row(input op_t kind, input logic [12:0] addr, input bit hit,
                                    input bit drain, input int burst,
                                    input logic [12:0] side);
        row_t row;
        row.kind  = kind;
        row.addr  = addr;
        row.hit   = hit;
        row.drain = drain;
        row.burst = burst;
        row.side  = side;
        row.data  = '0;
        if (kind == OP_STORE) begin
            row.data = {$urandom(), $urandom()};
            shadow[addr[12:3]] = row.data;
        end
        row.expected = shadow[addr[12:3]];
        rows.push_back(row);
    endfunction

    // Called just after a falling edge, returns on the accepting rising edge
    task automatic send_data(input mem_bus_pkg::bus_command_t command,
                             input logic [12:0] addr, input logic [63:0] data,
                             input logic [63:0] expected);
        load_entry_t entry;
        dmem_request.command = command;
        dmem_request.address = addr;
        dmem_request.data    = data;
        @(posedge clock);
        while (dmem_reply.response == '0) begin
            @(posedge clock);
        end
        if (command == mem_bus_pkg::BUS_LOAD) begin
            if (pending.size() > 0) begin
                compare("dmem_reply.response != previous", dmem_reply.response != last_tag,
                        1'b1);
            end
            entry.tag      = dmem_reply.response;
            entry.expected = expected;
            entry.accepted = $time;
            pending.push_back(entry);
            last_tag = dmem_reply.response;
        end
    endtask

    task automatic drain_loads();
        while (pending.size() != 0) begin
            @(posedge clock);
        end
    endtask

    task automatic run_fetch(input row_t row);
        logic [12:0] side_addr;
        @(negedge clock);
        fetch_valid = 1'b1;
        fetch_addr  = row.addr;
        if (row.burst > 0) begin
            for (int k = 0; k < row.burst; k++) begin
                side_addr = row.side + 13'(8 * k);
                if (k > 0) begin
                    @(negedge clock);
                end
                send_data(mem_bus_pkg::BUS_LOAD, side_addr, '0, shadow[side_addr[12:3]]);
                compare("fetch_hit", fetch_hit, 1'b0);
                if (k == 0) begin
                    // Cache asks in the same cycle and is refused
                    compare("uut.imem_request.command", uut.imem_request.command,
                            mem_bus_pkg::BUS_LOAD);
                    compare("uut.imem_reply.response", uut.imem_reply.response, '0);
                end
            end
            @(negedge clock);
            dmem_request = '0;
            @(posedge clock);
        end else begin
            @(posedge clock);
            compare("fetch_hit", fetch_hit, row.hit);
        end
        while (!fetch_hit) begin
            @(posedge clock);
        end
        compare("fetch_data", fetch_data, row.expected);
        @(negedge clock);
        fetch_valid = 1'b0;
        drain_loads();
    endtask

    // Load returns are matched by tag, oldest first
    always @(posedge clock) begin
        if (!reset && pending.size() > 0 && dmem_reply.tag == pending[0].tag) begin
            returned = pending.pop_front();
            compare("dmem_reply.data", dmem_reply.data, returned.expected);
            compare("dmem_reply.tag latency", ($time - returned.accepted) / 100,
                    `MEM_LATENCY);
        end
    end

    initial begin
        void'($urandom(32'h9a65_c568));
        reset        = 1'b1;
        dmem_request = '0;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadow[i] = {32'hc0de_0000, 32'(i)};
        end

        // kind, address, hit, drain, burst, side address
        add_row(OP_STORE, 13'h0100, 1'b0, 1'b0, 0, 13'h0000);
        add_row(OP_LOAD,  13'h0100, 1'b0, 1'b1, 0, 13'h0000);
        add_row(OP_FETCH, 13'h0400, 1'b0, 1'b0, 0, 13'h0000);
        add_row(OP_FETCH, 13'h0404, 1'b1, 1'b0, 0, 13'h0000);
        add_row(OP_LOAD,  13'h0208, 1'b0, 1'b0, 0, 13'h0000);
        add_row(OP_LOAD,  13'h0210, 1'b0, 1'b0, 0, 13'h0000);
        add_row(OP_LOAD,  13'h0218, 1'b0, 1'b1, 0, 13'h0000);
        add_row(OP_FETCH, 13'h0a48, 1'b0, 1'b0, 1, 13'h0300);
        add_row(OP_FETCH, 13'h1150, 1'b0, 1'b0, 6, 13'h0340);
        add_row(OP_STORE, 13'h1ff8, 1'b0, 1'b0, 0, 13'h0000);
        add_row(OP_LOAD,  13'h1ff8, 1'b0, 1'b1, 0, 13'h0000);
        add_row(OP_FETCH, 13'h0a4c, 1'b1, 1'b0, 0, 13'h0000);
        cycle_limit = rows.size() * (`MEM_LATENCY + 20);

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        @(posedge clock);
        compare("dmem_reply.response", dmem_reply.response, '0);
        compare("dmem_reply.tag", dmem_reply.tag, '0);
        compare("fetch_hit", fetch_hit, 1'b0);

        foreach (rows[i]) begin
            case (rows[i].kind)
                OP_FETCH: begin
                    run_fetch(rows[i]);
                end
                default: begin
                    @(negedge clock);
                    if (rows[i].kind == OP_STORE) begin
                        send_data(mem_bus_pkg::BUS_STORE, rows[i].addr, rows[i].data, '0);
                    end else begin
                        send_data(mem_bus_pkg::BUS_LOAD, rows[i].addr, '0, rows[i].expected);
                    end
                    if (rows[i].drain) begin
                        @(negedge clock);
                        dmem_request = '0;
                        drain_loads();
                    end
                end
            endcase
        end

        @(negedge clock);
        dmem_request = '0;
        drain_loads();
        repeat (2) @(posedge clock);

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
